// File: src/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    // width of one bus word and of a byte address
    localparam int WORD_W = 32;

    // byte lane select inside a word
    localparam int BYTE_OFF_W = 2;

    // one word as it travels on the memory bus
    typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// File: src/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    import mem_types_pkg::*;

    // two ways of eight sets, two words per block
    localparam int WAYS = 2;
    localparam int SETS = 8;
    localparam int BLOCK_WORDS = 2;

    localparam int IDX_W = 3;
    localparam int BLK_W = 1;
    localparam int TAG_W = WORD_W - IDX_W - BLK_W - BYTE_OFF_W;

    typedef logic [$clog2(WAYS)-1:0] way_t;

    // field view of a byte address, msb first
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [IDX_W-1:0]      idx;
        logic [BLK_W-1:0]      blkoff;
        logic [BYTE_OFF_W-1:0] bytoff;
    } dcache_addr_fields_t;

    // same 32 bits, flat or split
    typedef union packed {
        word_t               word;
        dcache_addr_fields_t f;
    } dcache_addr_t;

    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [TAG_W-1:0]             tag;
        word_t [BLOCK_WORDS-1:0]      data;
    } dcache_frame_t;

endpackage

`default_nettype wire

// File: src/dcache_array_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dcache_array_if;

    import mem_types_pkg::*;
    import dcache_geom_pkg::*;

    // lookup side
    dcache_addr_t     lookup_addr;
    logic             touch;
    logic             hit;
    way_t             hit_way;
    word_t            hit_word;
    way_t             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    // selected frame, also the target set of every write and flag update
    logic [IDX_W-1:0] sel_idx;
    way_t             sel_way;
    logic [BLK_W-1:0] sel_blk;
    word_t            sel_word;
    logic [TAG_W-1:0] sel_tag;
    logic             sel_dirty;

    // one word write per cycle
    logic             wr_en;
    way_t             wr_way;
    logic [BLK_W-1:0] wr_blk;
    word_t            wr_data;
    logic             fill_tag;
    logic             set_valid;
    logic             set_dirty;
    logic             clear_line;

    modport ctrl (
        output lookup_addr, touch, sel_idx, sel_way, sel_blk,
        output wr_en, wr_way, wr_blk, wr_data, fill_tag,
        output set_valid, set_dirty, clear_line,
        input  hit, hit_way, hit_word, victim_way, victim_dirty, victim_tag,
        input  sel_word, sel_tag, sel_dirty
    );

    modport array (
        input  lookup_addr, touch, sel_idx, sel_way, sel_blk,
        input  wr_en, wr_way, wr_blk, wr_data, fill_tag,
        input  set_valid, set_dirty, clear_line,
        output hit, hit_way, hit_word, victim_way, victim_dirty, victim_tag,
        output sel_word, sel_tag, sel_dirty
    );

endinterface

`default_nettype wire

// File: src/dcache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array (
    input logic           CLK,
    input logic           nRST,
    dcache_array_if.array arr
);

    import dcache_geom_pkg::*;

    dcache_frame_t    frames [WAYS][SETS];
    way_t [SETS-1:0]  lru;
    dcache_addr_t     la;
    logic [WAYS-1:0]  way_hit;
    way_t             hit_way;
    way_t             victim;
    logic [SETS-1:0]  dup_tag;

    assign la = arr.lookup_addr;

    // tag compare against both ways of the looked-up set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = frames[w][la.f.idx].valid && (frames[w][la.f.idx].tag == la.f.tag);
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign arr.hit = |way_hit;
    assign arr.hit_way = hit_way;
    assign arr.hit_word = frames[hit_way][la.f.idx].data[la.f.blkoff];

    // lru bit names the way to replace
    assign victim = lru[la.f.idx];
    assign arr.victim_way = victim;
    assign arr.victim_dirty = frames[victim][la.f.idx].dirty;
    assign arr.victim_tag = frames[victim][la.f.idx].tag;

    // read port for writebacks
    assign arr.sel_word = frames[arr.sel_way][arr.sel_idx].data[arr.sel_blk];
    assign arr.sel_tag = frames[arr.sel_way][arr.sel_idx].tag;
    assign arr.sel_dirty = frames[arr.sel_way][arr.sel_idx].dirty;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    frames[w][s].valid <= 1'b0;
                    frames[w][s].dirty <= 1'b0;
                end
            end
            lru <= '0;
        end else begin
            if (arr.wr_en) begin
                frames[arr.wr_way][arr.sel_idx].data[arr.wr_blk] <= arr.wr_data;
            end
            if (arr.fill_tag) begin
                frames[arr.wr_way][arr.sel_idx].tag <= la.f.tag;
            end
            // clear first, a set in the same cycle wins
            if (arr.clear_line) begin
                frames[arr.wr_way][arr.sel_idx].valid <= 1'b0;
                frames[arr.wr_way][arr.sel_idx].dirty <= 1'b0;
            end
            if (arr.set_valid) begin
                frames[arr.wr_way][arr.sel_idx].valid <= 1'b1;
            end
            if (arr.set_dirty) begin
                frames[arr.wr_way][arr.sel_idx].dirty <= 1'b1;
            end
            if (arr.touch) begin
                lru[la.f.idx] <= ~hit_way;
            end
        end
    end

    // a fill must never duplicate a tag already live in the other way
    always_comb begin
        for (int s = 0; s < SETS; s++) begin
            dup_tag[s] = frames[0][s].valid && frames[1][s].valid &&
                         (frames[0][s].tag == frames[1][s].tag);
        end
    end

    a_no_dup_tag: assert property (@(posedge CLK) disable iff (!nRST) dup_tag == '0)
        else $error("two valid ways of one set hold the same tag");

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmem_ren,
    input  logic                 dmem_wen,
    input  mem_types_pkg::word_t dmem_addr,
    input  mem_types_pkg::word_t dmem_store,
    input  logic                 halt,
    output mem_types_pkg::word_t dmem_load,
    output logic                 dhit,
    output logic                 flushed,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output mem_types_pkg::word_t mem_addr,
    output mem_types_pkg::word_t mem_store,
    input  mem_types_pkg::word_t mem_load,
    input  logic                 mem_wait,
    dcache_array_if.ctrl         arr
);

    import dcache_geom_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        FILL1,
        FILL2,
        HALT,
        HALT_WB1,
        HALT_WB2,
        DONE
    } state_t;

    state_t           state;
    state_t           next_state;
    dcache_addr_t     req;
    dcache_addr_t     mem_a;
    way_t             repl_way;
    logic [TAG_W-1:0] wb_tag;
    logic [IDX_W:0]   set_cnt;
    way_t             way_cnt;
    logic             halting;
    logic             access;
    logic [BLK_W-1:0] blk;
    logic [IDX_W-1:0] idx;
    logic             load_victim;
    logic             sweep_step;

    assign req.word = dmem_addr;
    assign access = dmem_ren | dmem_wen;
    assign halting = state inside {HALT, HALT_WB1, HALT_WB2, DONE};
    assign blk = (state == WB2) || (state == FILL2) || (state == HALT_WB2);

    // halt sweep walks the sets, otherwise follow the request
    assign idx = halting ? set_cnt[IDX_W-1:0] : req.f.idx;

    assign arr.lookup_addr = req;
    assign arr.sel_idx = idx;
    assign arr.sel_way = halting ? way_cnt : repl_way;
    assign arr.sel_blk = blk;
    assign arr.wr_blk = (state == IDLE) ? req.f.blkoff : blk;
    assign arr.wr_data = (state == IDLE) ? dmem_store : mem_load;
    assign arr.wr_way = (state == IDLE) ? arr.hit_way : (halting ? way_cnt : repl_way);

    assign dmem_load = arr.hit_word;
    assign flushed = (state == DONE);

    // block-aligned bus address
    always_comb begin
        mem_a.f.tag = req.f.tag;
        if (state == WB1 || state == WB2) begin
            mem_a.f.tag = wb_tag;
        end else if (state == HALT_WB1 || state == HALT_WB2) begin
            mem_a.f.tag = arr.sel_tag;
        end
        mem_a.f.idx = idx;
        mem_a.f.blkoff = blk;
        mem_a.f.bytoff = '0;
    end

    assign mem_addr = mem_a.word;
    assign mem_store = arr.sel_word;

    always_comb begin
        next_state = state;
        dhit = 1'b0;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        arr.touch = 1'b0;
        arr.wr_en = 1'b0;
        arr.fill_tag = 1'b0;
        arr.set_valid = 1'b0;
        arr.set_dirty = 1'b0;
        arr.clear_line = 1'b0;
        load_victim = 1'b0;
        sweep_step = 1'b0;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = HALT;
                end else if (access && arr.hit) begin
                    dhit = 1'b1;
                    arr.touch = 1'b1;
                    if (dmem_wen) begin
                        arr.wr_en = 1'b1;
                        arr.set_dirty = 1'b1;
                    end
                end else if (access) begin
                    load_victim = 1'b1;
                    next_state = arr.victim_dirty ? WB1 : FILL1;
                end
            end
            WB1: begin
                mem_wen = 1'b1;
                if (!mem_wait) begin
                    next_state = WB2;
                end
            end
            WB2: begin
                mem_wen = 1'b1;
                if (!mem_wait) begin
                    next_state = FILL1;
                end
            end
            FILL1: begin
                mem_ren = 1'b1;
                if (!mem_wait) begin
                    // old line dies here, new tag goes in
                    arr.wr_en = 1'b1;
                    arr.fill_tag = 1'b1;
                    arr.clear_line = 1'b1;
                    next_state = FILL2;
                end
            end
            FILL2: begin
                mem_ren = 1'b1;
                if (!mem_wait) begin
                    arr.wr_en = 1'b1;
                    arr.set_valid = 1'b1;
                    next_state = IDLE;
                end
            end
            HALT: begin
                if (set_cnt[IDX_W]) begin
                    next_state = DONE;
                end else if (arr.sel_dirty) begin
                    next_state = HALT_WB1;
                end else begin
                    sweep_step = 1'b1;
                end
            end
            HALT_WB1: begin
                mem_wen = 1'b1;
                if (!mem_wait) begin
                    next_state = HALT_WB2;
                end
            end
            HALT_WB2: begin
                mem_wen = 1'b1;
                if (!mem_wait) begin
                    arr.clear_line = 1'b1;
                    sweep_step = 1'b1;
                    next_state = HALT;
                end
            end
            DONE: begin
                next_state = DONE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            set_cnt <= '0;
            way_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && halt) begin
                set_cnt <= '0;
                way_cnt <= '0;
            end else if (sweep_step) begin
                {set_cnt, way_cnt} <= {set_cnt, way_cnt} + 1'b1;
            end
        end
    end

    // victim chosen at the miss, kept through writeback and fill
    always_ff @(posedge CLK) begin
        if (load_victim) begin
            repl_way <= arr.victim_way;
            wb_tag <= arr.victim_tag;
        end
    end

    a_one_request: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else $error("read and write requested together");

    a_bus_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_wait |=> $stable(mem_addr) && $stable(mem_store))
        else $error("bus address or data moved while waiting");

endmodule

`default_nettype wire

// File: src/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmem_ren,
    input  logic                 dmem_wen,
    input  mem_types_pkg::word_t dmem_addr,
    input  mem_types_pkg::word_t dmem_store,
    input  logic                 halt,
    output mem_types_pkg::word_t dmem_load,
    output logic                 dhit,
    output logic                 flushed,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output mem_types_pkg::word_t mem_addr,
    output mem_types_pkg::word_t mem_store,
    input  mem_types_pkg::word_t mem_load,
    input  logic                 mem_wait
);

    dcache_array_if arr_if ();

    // frames, lru and tag compare
    dcache_tag_array u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .arr  (arr_if.array)
    );

    // miss, writeback and halt sequencing
    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait),
        .arr        (arr_if.ctrl)
    );

endmodule

`default_nettype wire

// File: sim/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    import mem_types_pkg::*;

    localparam int N_ACCESS = 300;
    localparam int MEM_WORDS = 64;
    // worst case per access plus the flush sweep, with margin
    localparam int MAX_CYCLES = N_ACCESS * 4 * 4 + 8 * 2 * 2 * 4 + 1000;

    logic  CLK;
    logic  nRST;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
    word_t dmem_load;
    logic  dhit;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_store;
    word_t mem_load;
    logic  mem_wait;

    word_t       mem_model [MEM_WORDS];
    word_t       ref_mem [MEM_WORDS];
    logic [15:0] lfsr;
    int          data_errs;
    int          bus_errs;
    int          flow_errs;
    int          cycle_cnt;
    int          wait_left;
    logic        held;
    word_t       held_addr;
    word_t       held_store;
    logic        second_word;
    word_t       pair_addr;
    logic        pair_wen;

    dcache UUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic print_counts();
        $display("error counts: data %0d, bus %0d, flow %0d", data_errs, bus_errs, flow_errs);
    endtask

    // one processor access, held until dhit; returns 1 ns after the completing edge
    task automatic run_access(input logic wr, input logic [5:0] widx, input word_t data,
                              input logic must_hit);
        dmem_ren = !wr;
        dmem_wen = wr;
        dmem_addr = {24'h0, widx, 2'b00};
        dmem_store = data;
        @(negedge CLK);
        if (must_hit) begin
            assert (dhit && !mem_ren && !mem_wen) else begin
                flow_errs++;
                $display("repeated read of %h did not hit at once", dmem_addr);
            end
        end
        while (!dhit) begin
            @(negedge CLK);
        end
        if (wr) begin
            ref_mem[widx] = data;
        end else begin
            assert (dmem_load == ref_mem[widx]) else begin
                data_errs++;
                $display("ERROR dmem_load at %h: got %h expected %h",
                         dmem_addr, dmem_load, ref_mem[widx]);
            end
        end
        @(posedge CLK);
        #1;
    endtask

    // memory answers 1 ns after the edge
    always @(posedge CLK) begin
        #1;
        mem_wait = (wait_left != 0);
        mem_load = mem_model[mem_addr[7:2]];
    end

    // bus bookkeeping where the outputs are settled
    always @(negedge CLK) begin
        logic [31:0] r;
        if (nRST && (mem_ren || mem_wen)) begin
            if (held) begin
                assert (mem_addr == held_addr && mem_store == held_store) else begin
                    bus_errs++;
                    $display("ERROR mem_addr/mem_store moved during wait: %h/%h was %h/%h",
                             mem_addr, mem_store, held_addr, held_store);
                end
            end
            if (mem_wait) begin
                held = 1'b1;
                held_addr = mem_addr;
                held_store = mem_store;
                wait_left--;
            end else begin
                held = 1'b0;
                if (!second_word) begin
                    assert (mem_addr[2:0] == 3'b000 && mem_addr[31:8] == '0) else begin
                        bus_errs++;
                        $display("ERROR mem_addr first word: got %h", mem_addr);
                    end
                    pair_addr = mem_addr;
                    pair_wen = mem_wen;
                end else begin
                    assert (mem_addr == pair_addr + 32'd4 && mem_wen == pair_wen) else begin
                        bus_errs++;
                        $display("ERROR mem_addr second word: got %h expected %h",
                                 mem_addr, pair_addr + 32'd4);
                    end
                end
                second_word = !second_word;
                if (mem_wen) begin
                    mem_model[mem_addr[7:2]] = mem_store;
                end
                take_bits(2, r);
                wait_left = int'(r[1:0]);
            end
        end else begin
            held = 1'b0;
        end
        if (nRST && halt) begin
            assert (!dhit) else begin
                flow_errs++;
                $display("dhit rose while halt was high");
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic        wr;
        logic [5:0]  widx;
        word_t       wdata;
        nRST = 1'b0;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        dmem_addr = '0;
        dmem_store = '0;
        halt = 1'b0;
        mem_load = '0;
        mem_wait = 1'b0;
        lfsr = 16'd94;
        data_errs = 0;
        bus_errs = 0;
        flow_errs = 0;
        wait_left = 0;
        held = 1'b0;
        second_word = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = 32'hd000_0000 + i * 32'h0001_0203;
            ref_mem[i] = mem_model[i];
        end
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        assert (!mem_ren && !mem_wen && !dhit && !flushed) else begin
            flow_errs++;
            $display("outputs not idle after reset");
        end
        @(posedge CLK);
        #1;
        for (int k = 0; k < N_ACCESS; k++) begin
            take_bits(1, r);
            wr = r[0];
            take_bits(6, r);
            widx = r[5:0];
            // half the traffic crowds into set 2 to force evictions
            take_bits(1, r);
            if (r[0]) begin
                widx[3:1] = 3'd2;
            end
            take_bits(32, r);
            wdata = r;
            run_access(wr, widx, wdata, 1'b0);
            take_bits(1, r);
            if (r[0]) begin
                run_access(1'b0, widx, '0, 1'b1);
            end
        end
        // pending read of the last cached word while halt rises
        dmem_ren = 1'b1;
        dmem_wen = 1'b0;
        halt = 1'b1;
        while (!flushed) begin
            @(negedge CLK);
        end
        repeat (8) begin
            @(negedge CLK);
            assert (flushed) else begin
                flow_errs++;
                $display("flushed dropped after the flush");
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem_model[i] == ref_mem[i]) else begin
                data_errs++;
                $display("ERROR mem_model[%h]: got %h expected %h", i, mem_model[i], ref_mem[i]);
            end
        end
        print_counts();
        if (data_errs + bus_errs + flow_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/mem_types_pkg.sv
src/dcache_geom_pkg.sv
src/dcache_array_if.sv
src/dcache_tag_array.sv
src/dcache_ctrl.sv
src/dcache.sv
sim/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
